// ==== Bender.yml ====
package:
  name: sd_host

sources:
  - src/sd_host_pkg.sv
  - src/sd_host_platform.sv
  - src/sd_cmd_phy.sv
  - src/sd_data_phy.sv
  - src/sd_host.sv
  - target: test
    files:
      - tests/sd_host_properties.sv
      - tests/sd_host_tb.sv

// ==== sd_host.f ====
src/sd_host_pkg.sv
src/sd_host_platform.sv
src/sd_cmd_phy.sv
src/sd_data_phy.sv
src/sd_host.sv
tests/sd_host_properties.sv
tests/sd_host_tb.sv

// ==== src/sd_cmd_phy.sv ====
// sd command engine, sends 48-bit commands with crc7 and captures short responses
`timescale 1ns/1ps

module sd_cmd_phy (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   i_locked,
  input  logic                   i_sd_stb,
  input  logic                   i_cmd_start,
  input  sd_host_pkg::cmd_req_t  i_cmd_req,
  input  logic                   i_sd_cmd_in,
  output logic                   o_sd_cmd_dir,
  output logic                   o_sd_cmd_out,
  output logic                   o_cmd_busy,
  output logic                   o_cmd_done,
  output sd_host_pkg::cmd_resp_t o_cmd_resp
);
  import sd_host_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_SEND, S_WAIT, S_RECV} state_t;

  state_t               state_q;
  logic [CMD_BITS-1:0]  shift_q;    // tx bits out of the top, rx bits in at the bottom
  logic [CMD_CNT_W-1:0] bit_cnt_q;  // frame bit position
  logic [RESP_TO_W-1:0] to_cnt_q;   // response start bit timeout
  logic [6:0]           crc_q;      // shared tx/rx crc7
  logic                 resp_en_q;
  logic                 accept;

  // serial crc7, x^7 + x^3 + 1
  function automatic logic [6:0] crc7_next(input logic [6:0] crc, input logic bit_in);
    logic fb;
    fb = crc[6] ^ bit_in;
    return {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
  endfunction

  assign accept = (state_q == S_IDLE) && i_cmd_start && i_locked;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q      <= S_IDLE;
      o_sd_cmd_dir <= 1'b0;
      o_sd_cmd_out <= 1'b1;  // line idles high
      o_cmd_busy   <= 1'b0;
      o_cmd_done   <= 1'b0;
      o_cmd_resp   <= '0;
      bit_cnt_q    <= '0;
      to_cnt_q     <= '0;
    end else begin
      o_cmd_done <= 1'b0;
      case (state_q)
        S_IDLE: if (accept) begin
          // start bit, host direction bit, index, argument
          shift_q    <= {1'b0, 1'b1, i_cmd_req.index, i_cmd_req.arg, 8'h00};
          resp_en_q  <= i_cmd_req.resp_en;
          crc_q      <= '0;
          bit_cnt_q  <= '0;
          o_cmd_busy <= 1'b1;
          state_q    <= S_SEND;
        end
        S_SEND: if (i_sd_stb) begin
          bit_cnt_q <= bit_cnt_q + 1'b1;
          shift_q   <= {shift_q[CMD_BITS-2:0], 1'b0};
          if (bit_cnt_q < CMD_CNT_W'(CMD_BITS - 8)) begin
            o_sd_cmd_dir <= 1'b1;
            o_sd_cmd_out <= shift_q[CMD_BITS-1];
            crc_q        <= crc7_next(crc_q, shift_q[CMD_BITS-1]);
          end else if (bit_cnt_q < CMD_CNT_W'(CMD_BITS - 1)) begin
            o_sd_cmd_out <= crc_q[6];  // crc msb first
            crc_q        <= {crc_q[5:0], 1'b0};
          end else if (bit_cnt_q == CMD_CNT_W'(CMD_BITS - 1)) begin
            o_sd_cmd_out <= 1'b1;  // end bit
          end else begin
            // card clocked the end bit on this edge, let go of the line
            o_sd_cmd_dir <= 1'b0;
            crc_q        <= '0;
            bit_cnt_q    <= '0;
            to_cnt_q     <= '0;
            if (resp_en_q) begin
              state_q <= S_WAIT;
            end else begin
              o_cmd_resp <= '0;
              o_cmd_done <= 1'b1;
              o_cmd_busy <= 1'b0;
              state_q    <= S_IDLE;
            end
          end
        end
        S_WAIT: if (i_sd_stb) begin
          if (!i_sd_cmd_in) begin  // response start bit
            shift_q   <= {shift_q[CMD_BITS-2:0], i_sd_cmd_in};
            crc_q     <= crc7_next(crc_q, i_sd_cmd_in);
            bit_cnt_q <= CMD_CNT_W'(1);
            state_q   <= S_RECV;
          end else if (to_cnt_q == RESP_TO_W'(RESP_TIMEOUT - 1)) begin
            o_cmd_resp <= '{index: '0, arg: '0, crc_ok: 1'b0, end_ok: 1'b0, timeout: 1'b1};
            o_cmd_done <= 1'b1;
            o_cmd_busy <= 1'b0;
            state_q    <= S_IDLE;
          end else begin
            to_cnt_q <= to_cnt_q + 1'b1;
          end
        end
        S_RECV: if (i_sd_stb) begin
          shift_q   <= {shift_q[CMD_BITS-2:0], i_sd_cmd_in};
          bit_cnt_q <= bit_cnt_q + 1'b1;
          if (bit_cnt_q < CMD_CNT_W'(CMD_BITS - 8)) begin
            crc_q <= crc7_next(crc_q, i_sd_cmd_in);  // first 40 bits only
          end
          if (bit_cnt_q == CMD_CNT_W'(CMD_BITS - 1)) begin
            // frame bit k sits at shift_q[k-1], this bit is the end bit
            o_cmd_resp <= '{index:   shift_q[44:39],
                            arg:     shift_q[38:7],
                            crc_ok:  (shift_q[6:0] == crc_q),
                            end_ok:  i_sd_cmd_in,
                            timeout: 1'b0};
            o_cmd_done <= 1'b1;
            o_cmd_busy <= 1'b0;
            state_q    <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

endmodule

// ==== src/sd_data_phy.sv ====
// sd data write engine, one block on four lanes with per-lane crc16 and busy wait
`timescale 1ns/1ps

module sd_data_phy (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    i_locked,
  input  logic                    i_sd_stb,
  input  logic                    i_data_start,
  input  sd_host_pkg::blk_t       i_blk,
  input  logic [3:0]              i_sd_data_in,
  output logic                    o_sd_data_dir,
  output logic [7:0]              o_sd_data_out,
  output logic                    o_data_busy,
  output logic                    o_data_done,
  output sd_host_pkg::data_stat_t o_data_stat
);
  import sd_host_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_SEND, S_WAIT} state_t;

  state_t                   state_q;
  logic [BLOCK_BYTES*8-1:0] shift_q;     // payload, next byte on top
  logic [3:0][15:0]         crc_q;       // one crc16 per lane
  logic [DATA_CNT_W-1:0]    byte_cnt_q;  // byte slot in the block
  logic [BUSY_TO_W-1:0]     wait_cnt_q;  // busy timeout
  logic                     accept;

  // serial crc16, x^16 + x^12 + x^5 + 1
  function automatic logic [15:0] crc16_next(input logic [15:0] crc, input logic bit_in);
    logic fb;
    fb = crc[15] ^ bit_in;
    return {crc[14:0], 1'b0} ^ (fb ? 16'h1021 : 16'h0000);
  endfunction

  // high nibble bit first, then low nibble bit
  function automatic logic [15:0] crc16_pair(input logic [15:0] crc, input logic hi,
                                             input logic lo);
    return crc16_next(crc16_next(crc, hi), lo);
  endfunction

  assign accept = (state_q == S_IDLE) && i_data_start && i_locked;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q       <= S_IDLE;
      o_sd_data_dir <= 1'b0;
      o_data_busy   <= 1'b0;
      o_data_done   <= 1'b0;
      o_data_stat   <= '0;
      byte_cnt_q    <= '0;
      wait_cnt_q    <= '0;
    end else begin
      o_data_done <= 1'b0;
      case (state_q)
        S_IDLE: if (accept) begin
          shift_q     <= i_blk.data;
          crc_q       <= '0;
          byte_cnt_q  <= '0;
          o_data_busy <= 1'b1;
          state_q     <= S_SEND;
        end
        S_SEND: if (i_sd_stb) begin
          byte_cnt_q <= byte_cnt_q + 1'b1;
          if (byte_cnt_q == '0) begin
            o_sd_data_dir <= 1'b1;
            o_sd_data_out <= 8'h00;  // start nibble on every lane
          end else if (byte_cnt_q <= DATA_CNT_W'(BLOCK_BYTES)) begin
            o_sd_data_out <= shift_q[BLOCK_BYTES*8-1 -: 8];
            shift_q       <= shift_q << 8;
            for (int i = 0; i < 4; i++) begin
              crc_q[i] <= crc16_pair(crc_q[i], shift_q[BLOCK_BYTES*8-4+i],
                                     shift_q[BLOCK_BYTES*8-8+i]);
            end
          end else if (byte_cnt_q <= DATA_CNT_W'(BLOCK_BYTES + CRC16_BYTES)) begin
            // two crc bits per lane per byte, msb first
            for (int i = 0; i < 4; i++) begin
              o_sd_data_out[4+i] <= crc_q[i][15];
              o_sd_data_out[i]   <= crc_q[i][14];
              crc_q[i]           <= crc_q[i] << 2;
            end
          end else if (byte_cnt_q == DATA_CNT_W'(BLOCK_BYTES + CRC16_BYTES + 1)) begin
            o_sd_data_out <= 8'hFF;  // end nibble on every lane
          end else begin
            o_sd_data_dir <= 1'b0;  // platform finishes the end byte, then floats
            wait_cnt_q    <= '0;
            state_q       <= S_WAIT;
          end
        end
        S_WAIT: if (i_sd_stb) begin
          // first wait strobe is turnaround, card may not hold dat0 yet
          // busy is on dat0, the other lanes idle high
          if ((wait_cnt_q != '0) && (&i_sd_data_in)) begin
            o_data_stat <= '{busy_timeout: 1'b0, done_ok: 1'b1};
            o_data_done <= 1'b1;
            o_data_busy <= 1'b0;
            state_q     <= S_IDLE;
          end else if (wait_cnt_q == BUSY_TO_W'(BUSY_TIMEOUT - 1)) begin
            o_data_stat <= '{busy_timeout: 1'b1, done_ok: 1'b0};
            o_data_done <= 1'b1;
            o_data_busy <= 1'b0;
            state_q     <= S_IDLE;
          end else begin
            wait_cnt_q <= wait_cnt_q + 1'b1;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

endmodule

// ==== src/sd_host.sv ====
// sd host phy top, platform pads plus command and data write engines
`timescale 1ns/1ps

module sd_host (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    i_cmd_start,
  input  sd_host_pkg::cmd_req_t   i_cmd_req,
  input  logic                    i_data_start,
  input  sd_host_pkg::blk_t       i_blk,
  output logic                    o_locked,
  output logic                    o_cmd_busy,
  output logic                    o_cmd_done,
  output sd_host_pkg::cmd_resp_t  o_cmd_resp,
  output logic                    o_data_busy,
  output logic                    o_data_done,
  output sd_host_pkg::data_stat_t o_data_stat,
  output logic                    o_phy_clk,
  inout  wire                     io_phy_cmd,
  inout  wire  [3:0]              io_phy_data
);

  logic       sd_stb;       // card clock rising edge
  logic       sd_cmd_dir;
  logic       sd_cmd_out;
  logic       sd_cmd_in;
  logic       sd_data_dir;
  logic [7:0] sd_data_out;  // one byte per card clock
  logic [3:0] sd_data_in;

  sd_host_platform platform0 (
    .clk           (clk),
    .rst           (rst),
    .i_sd_cmd_dir  (sd_cmd_dir),
    .i_sd_cmd_out  (sd_cmd_out),
    .i_sd_data_dir (sd_data_dir),
    .i_sd_data_out (sd_data_out),
    .o_locked      (o_locked),
    .o_sd_stb      (sd_stb),
    .o_sd_cmd_in   (sd_cmd_in),
    .o_sd_data_in  (sd_data_in),
    .o_phy_clk     (o_phy_clk),
    .io_phy_cmd    (io_phy_cmd),
    .io_phy_data   (io_phy_data)
  );

  sd_cmd_phy cmd0 (
    .clk          (clk),
    .rst          (rst),
    .i_locked     (o_locked),
    .i_sd_stb     (sd_stb),
    .i_cmd_start  (i_cmd_start),
    .i_cmd_req    (i_cmd_req),
    .i_sd_cmd_in  (sd_cmd_in),
    .o_sd_cmd_dir (sd_cmd_dir),
    .o_sd_cmd_out (sd_cmd_out),
    .o_cmd_busy   (o_cmd_busy),
    .o_cmd_done   (o_cmd_done),
    .o_cmd_resp   (o_cmd_resp)
  );

  sd_data_phy data0 (
    .clk           (clk),
    .rst           (rst),
    .i_locked      (o_locked),
    .i_sd_stb      (sd_stb),
    .i_data_start  (i_data_start),
    .i_blk         (i_blk),
    .i_sd_data_in  (sd_data_in),
    .o_sd_data_dir (sd_data_dir),
    .o_sd_data_out (sd_data_out),
    .o_data_busy   (o_data_busy),
    .o_data_done   (o_data_done),
    .o_data_stat   (o_data_stat)
  );

endmodule

// ==== src/sd_host_pkg.sv ====
// sd host phy package, timing constants and the request/result structs
package sd_host_pkg;

  // platform
  localparam int LOCK_CYCLES  = 16;   // clk cycles held unlocked after reset

  // command path
  localparam int CMD_BITS     = 48;   // command and short response frame
  localparam int RESP_TIMEOUT = 64;   // card clocks to wait for a response start bit

  // data path
  localparam int BLOCK_BYTES  = 8;    // payload bytes per write block
  localparam int CRC16_BYTES  = 8;    // 16 crc bits per lane, two bits per byte
  localparam int BUSY_TIMEOUT = 256;  // card clocks to wait for dat0 release

  // counter widths
  localparam int LOCK_W     = $clog2(LOCK_CYCLES + 1);
  localparam int CMD_CNT_W  = $clog2(CMD_BITS + 1);   // counts 0..48
  localparam int RESP_TO_W  = $clog2(RESP_TIMEOUT);
  localparam int BUSY_TO_W  = $clog2(BUSY_TIMEOUT);
  // start byte, payload, crc bytes, end byte, release slot
  localparam int DATA_CNT_W = $clog2(BLOCK_BYTES + CRC16_BYTES + 3);

  // command request, sampled on the start pulse
  typedef struct packed {
    logic [5:0]  index;
    logic [31:0] arg;
    logic        resp_en;  // 48-bit response expected
  } cmd_req_t;

  // response result, held from done until the next start
  typedef struct packed {
    logic [5:0]  index;
    logic [31:0] arg;
    logic        crc_ok;   // crc7 over first 40 bits matched
    logic        end_ok;   // end bit was 1
    logic        timeout;  // no start bit seen
  } cmd_resp_t;

  // write payload
  // byte 0 lives in data[63:56] and goes out first, high nibble then low
  typedef struct packed {
    logic [BLOCK_BYTES*8-1:0] data;
  } blk_t;

  // write result
  typedef struct packed {
    logic busy_timeout;  // dat0 held low too long
    logic done_ok;       // card released busy in time
  } data_stat_t;

endpackage

// ==== src/sd_host_platform.sv ====
// sd host platform, card clock divider, lock delay, edge strobe and tristate pads
`timescale 1ns/1ps

module sd_host_platform (
  input  logic       clk,
  input  logic       rst,
  input  logic       i_sd_cmd_dir,
  input  logic       i_sd_cmd_out,
  input  logic       i_sd_data_dir,
  input  logic [7:0] i_sd_data_out,
  output logic       o_locked,
  output logic       o_sd_stb,
  output logic       o_sd_cmd_in,
  output logic [3:0] o_sd_data_in,
  output logic       o_phy_clk,
  inout  wire        io_phy_cmd,
  inout  wire  [3:0] io_phy_data
);
  import sd_host_pkg::*;

  logic [LOCK_W-1:0] lock_cnt_q;  // cycles since reset release
  logic              data_dir_q;  // pad enable, aligned to data_nib_q
  logic [3:0]        data_nib_q;  // nibble on the data pads

  // clock divider, strobe and lock
  always_ff @(posedge clk) begin
    if (rst) begin
      o_phy_clk  <= 1'b0;
      o_sd_stb   <= 1'b0;
      lock_cnt_q <= '0;
      o_locked   <= 1'b0;
      data_dir_q <= 1'b0;
    end else begin
      o_phy_clk <= ~o_phy_clk;  // card clock = clk / 2
      // registered rising edge detect
      // high in the cycle where the pad clock has just gone high
      o_sd_stb  <= ~o_phy_clk;
      if (lock_cnt_q < LOCK_W'(LOCK_CYCLES)) begin
        lock_cnt_q <= lock_cnt_q + 1'b1;
      end else begin
        o_locked <= 1'b1;
      end
      data_dir_q <= i_sd_data_dir;  // follows the nibble register
    end
  end

  // ddr nibble mux
  // engines change their byte as the pad clock falls, so the byte is
  // picked up one cycle later: high nibble lands in the high phase,
  // low nibble in the following low phase
  always_ff @(posedge clk) begin
    if (o_phy_clk) begin
      data_nib_q <= i_sd_data_out[3:0];  // next phase is low
    end else begin
      data_nib_q <= i_sd_data_out[7:4];  // next phase is high
    end
  end

  // cmd pad, driven straight from the engine
  assign io_phy_cmd   = i_sd_cmd_dir ? i_sd_cmd_out : 1'bz;
  assign o_sd_cmd_in  = io_phy_cmd;

  // data pads
  assign io_phy_data  = data_dir_q ? data_nib_q : 4'bzzzz;
  assign o_sd_data_in = io_phy_data;  // dat0 busy comes back here

endmodule

// ==== tests/sd_host_properties.sv ====
// sd engine checker for pad direction, done pulse shape and lock gating
`timescale 1ns/1ps

module sd_host_properties (
  input logic clk,
  input logic rst,
  input logic i_locked,
  input logic i_busy,
  input logic i_done,
  input logic i_dir
);

  int unsigned fail_cnt = 0;  // failed assertions so far

  // idle engine keeps its pads released
  a_dir_idle: assert property (@(posedge clk) disable iff (rst) !i_busy |-> !i_dir)
    else begin
      $error("pad driven while the engine is idle");
      fail_cnt++;
    end

  a_done_pulse: assert property (@(posedge clk) disable iff (rst) i_done |=> !i_done)
    else begin
      $error("done pulse longer than one cycle");
      fail_cnt++;
    end

  // start is only taken once locked
  a_busy_lock: assert property (@(posedge clk) disable iff (rst) $rose(i_busy) |-> $past(i_locked))
    else begin
      $error("busy rose while lock was low");
      fail_cnt++;
    end

endmodule

bind sd_cmd_phy sd_host_properties cmd_props (
  .clk      (clk),
  .rst      (rst),
  .i_locked (i_locked),
  .i_busy   (o_cmd_busy),
  .i_done   (o_cmd_done),
  .i_dir    (o_sd_cmd_dir)
);

bind sd_data_phy sd_host_properties data_props (
  .clk      (clk),
  .rst      (rst),
  .i_locked (i_locked),
  .i_busy   (o_data_busy),
  .i_done   (o_data_done),
  .i_dir    (o_sd_data_dir)
);

// ==== tests/sd_host_tb.sv ====
// sd host phy testbench driving random commands and write blocks against a card model
`timescale 1ns/1ps

module sd_host_tb;
  import sd_host_pkg::*;

  logic       clk;
  logic       rst;
  logic       i_cmd_start;
  cmd_req_t   i_cmd_req;
  logic       i_data_start;
  blk_t       i_blk;
  logic       o_locked;
  logic       o_cmd_busy;
  logic       o_cmd_done;
  cmd_resp_t  o_cmd_resp;
  logic       o_data_busy;
  logic       o_data_done;
  data_stat_t o_data_stat;
  logic       o_phy_clk;
  wire        phy_cmd;
  wire  [3:0] phy_data;

  logic        card_cmd_oe;  // card model drives cmd
  logic        card_cmd;
  logic        card_busy;    // card holds dat0 low
  logic [31:0] lcg_state;

  // open drain style pads that idle high
  pullup (phy_cmd);
  pullup (phy_data[0]);
  pullup (phy_data[1]);
  pullup (phy_data[2]);
  pullup (phy_data[3]);
  assign phy_cmd     = card_cmd_oe ? card_cmd : 1'bz;
  assign phy_data[0] = card_busy ? 1'b0 : 1'bz;

  sd_host dut0 (
    .clk          (clk),
    .rst          (rst),
    .i_cmd_start  (i_cmd_start),
    .i_cmd_req    (i_cmd_req),
    .i_data_start (i_data_start),
    .i_blk        (i_blk),
    .o_locked     (o_locked),
    .o_cmd_busy   (o_cmd_busy),
    .o_cmd_done   (o_cmd_done),
    .o_cmd_resp   (o_cmd_resp),
    .o_data_busy  (o_data_busy),
    .o_data_done  (o_data_done),
    .o_data_stat  (o_data_stat),
    .o_phy_clk    (o_phy_clk),
    .io_phy_cmd   (phy_cmd),
    .io_phy_data  (phy_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // crc7 by long division over x^7 + x^3 + 1
  function automatic logic [6:0] crc7_of(input logic [39:0] msg);
    logic [46:0] rem;
    rem = {msg, 7'b0};
    for (int i = 46; i >= 7; i--) begin
      if (rem[i])
        rem[i -: 8] = rem[i -: 8] ^ 8'h89;
    end
    return rem[6:0];
  endfunction

  // crc16 of one lane over x^16 + x^12 + x^5 + 1
  function automatic logic [15:0] crc16_of(input logic [15:0] bits);
    logic [31:0] rem;
    rem = {bits, 16'b0};
    for (int i = 31; i >= 16; i--) begin
      if (rem[i])
        rem[i -: 17] = rem[i -: 17] ^ 17'h11021;
    end
    return rem[15:0];
  endfunction

  task automatic fail_run(input string line);
    $display("%s", line);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp)
      else fail_run($sformatf("** Error at %0t: %s = %0h, expected %0h",
                              $time, name, got, exp));
  endtask

  // next falling clk edge inside the wanted pad clock phase
  task automatic wait_phase(input logic hi);
    for (int n = 0; n < 4; n++) begin
      @(negedge clk);
      if (o_phy_clk === hi)
        return;
    end
    fail_run($sformatf("o_phy_clk stopped toggling at %0t", $time));
  endtask

  task automatic wait_done(input logic data_side, input int limit);
    for (int n = 0; n < limit; n++) begin
      @(negedge clk);
      if (data_side ? o_data_done : o_cmd_done)
        return;
    end
    fail_run($sformatf("timeout at %0t: no done pulse from the %s engine",
                       $time, data_side ? "data" : "command"));
  endtask

  // cmd bits read mid high phase hold the value seen at the pad clock rise
  task automatic capture_cmd(output logic [47:0] frame);
    int n;
    n = 0;
    frame = '0;
    wait_phase(1'b1);
    while (phy_cmd !== 1'b0) begin  // hunt for start bit
      if (n == 40)
        fail_run($sformatf("no command start bit on the pad by %0t", $time));
      n++;
      wait_phase(1'b1);
    end
    for (int b = 46; b >= 0; b--) begin
      wait_phase(1'b1);
      frame[b] = phy_cmd;
    end
  endtask

  // card changes cmd mid low phase and the host samples at the end of high
  task automatic drive_response(input logic [47:0] frame, input int gap);
    repeat (gap) wait_phase(1'b0);  // ncr turnaround
    for (int b = 47; b >= 0; b--) begin
      wait_phase(1'b0);
      card_cmd    = frame[b];
      card_cmd_oe = 1'b1;
    end
    wait_phase(1'b0);
    card_cmd_oe = 1'b0;
  endtask

  // mode 0 no response, 1 good, 2 bad crc, 3 silent card
  task automatic run_command(input int mode);
    cmd_req_t    req;
    logic [47:0] exp_frame;
    logic [47:0] got_frame;
    logic [47:0] rsp_frame;
    logic [31:0] r;
    int          flip;
    r = next_rand();
    req.index   = r[29:24];
    req.arg     = next_rand();
    req.resp_en = (mode != 0);
    exp_frame = {2'b01, req.index, req.arg, crc7_of({2'b01, req.index, req.arg}), 1'b1};
    rsp_frame[47:8] = {2'b00, r[13:8], next_rand()};
    rsp_frame[7:0]  = {crc7_of(rsp_frame[47:8]), 1'b1};
    flip = 1 + int'(r[2:0]) % 7;  // somewhere in the crc field
    if (mode == 2)
      rsp_frame[flip] = ~rsp_frame[flip];
    @(negedge clk);
    i_cmd_req   = req;
    i_cmd_start = 1'b1;
    @(negedge clk);
    i_cmd_start = 1'b0;
    capture_cmd(got_frame);
    check_value("io_phy_cmd frame", got_frame, exp_frame);
    fork
      begin
        if (mode == 1 || mode == 2)
          drive_response(rsp_frame, 2 + int'(r[18:16]));
      end
      wait_done(1'b0, 400);
    join
    check_value("o_cmd_busy", o_cmd_busy, 1'b0);
    check_value("o_cmd_resp.timeout", o_cmd_resp.timeout, mode == 3);
    if (mode == 1 || mode == 2) begin
      check_value("o_cmd_resp.index", o_cmd_resp.index, rsp_frame[45:40]);
      check_value("o_cmd_resp.arg", o_cmd_resp.arg, rsp_frame[39:8]);
      check_value("o_cmd_resp.crc_ok", o_cmd_resp.crc_ok, mode == 1);
      check_value("o_cmd_resp.end_ok", o_cmd_resp.end_ok, 1'b1);
    end
  endtask

  task automatic run_block(input logic hold_long);
    blk_t        blk;
    logic [3:0]  exp_nib [0:35];  // start, payload, crc, end
    logic [15:0] lane [0:3];
    logic [15:0] crc [0:3];
    logic [31:0] r;
    int          n;
    int          hold;
    r = next_rand();
    blk.data = {next_rand(), next_rand()};
    exp_nib[0]  = 4'h0;
    exp_nib[1]  = 4'h0;
    exp_nib[34] = 4'hf;
    exp_nib[35] = 4'hf;
    for (int k = 0; k < 16; k++) begin
      exp_nib[2 + k] = blk.data[63 - 4 * k -: 4];  // byte 0 high nibble first
      for (int i = 0; i < 4; i++)
        lane[i][15 - k] = exp_nib[2 + k][i];
    end
    for (int i = 0; i < 4; i++)
      crc[i] = crc16_of(lane[i]);
    for (int k = 0; k < 16; k++) begin
      for (int i = 0; i < 4; i++)
        exp_nib[18 + k][i] = crc[i][15 - k];  // crc msb first per lane
    end
    @(negedge clk);
    i_blk        = blk;
    i_data_start = 1'b1;
    @(negedge clk);
    i_data_start = 1'b0;
    n = 0;
    while (phy_data !== 4'h0) begin
      if (n == 20)
        fail_run($sformatf("no data start nibble on the pads by %0t", $time));
      n++;
      @(negedge clk);
    end
    check_value("o_phy_clk at start nibble", o_phy_clk, 1'b1);
    for (int k = 1; k < 36; k++) begin
      @(negedge clk);  // one nibble per clk read mid phase
      check_value($sformatf("io_phy_data nibble %0d", k), phy_data, exp_nib[k]);
    end
    hold = hold_long ? 2 * (BUSY_TIMEOUT + 20) : 2 * (1 + int'(r[31:16] % 40));
    fork
      begin
        @(negedge clk);  // host pads float by now
        card_busy = 1'b1;
        repeat (hold) @(negedge clk);
        // host keeps waiting unless dat0 outlasted the busy timeout
        check_value("o_data_busy at busy release", o_data_busy, !hold_long);
        card_busy = 1'b0;
      end
      wait_done(1'b1, 4 * BUSY_TIMEOUT);
    join
    check_value("o_data_busy", o_data_busy, 1'b0);
    check_value("o_data_stat.done_ok", o_data_stat.done_ok, !hold_long);
    check_value("o_data_stat.busy_timeout", o_data_stat.busy_timeout, hold_long);
  endtask

  // bound checkers flag pad or pulse faults
  always @(negedge clk) begin
    if (dut0.cmd0.cmd_props.fail_cnt + dut0.data0.data_props.fail_cnt != 0)
      fail_run("a bound concurrent assertion failed on an engine");
  end

  initial begin
    logic [31:0] r;
    int          count;
    logic        prev_clk;
    lcg_state    = 32'h09c1_8822;
    rst          = 1'b1;
    i_cmd_start  = 1'b0;
    i_cmd_req    = '0;
    i_data_start = 1'b0;
    i_blk        = '0;
    card_cmd_oe  = 1'b0;
    card_cmd     = 1'b1;
    card_busy    = 1'b0;
    repeat (2) @(negedge clk);
    check_value("o_locked", o_locked, 1'b0);
    check_value("o_cmd_busy", o_cmd_busy, 1'b0);
    check_value("o_data_busy", o_data_busy, 1'b0);
    check_value("o_cmd_done", o_cmd_done, 1'b0);
    check_value("o_data_done", o_data_done, 1'b0);
    rst          = 1'b0;
    count        = 0;
    prev_clk     = o_phy_clk;
    i_cmd_start  = 1'b1;  // both ignored while unlocked
    i_data_start = 1'b1;
    repeat (LOCK_CYCLES + 4) begin
      @(negedge clk);
      i_cmd_start  = 1'b0;
      i_data_start = 1'b0;
      check_value("o_phy_clk", o_phy_clk, !prev_clk);
      check_value("o_cmd_busy", o_cmd_busy, 1'b0);
      check_value("o_data_busy", o_data_busy, 1'b0);
      prev_clk = o_phy_clk;
      if (!o_locked)
        count++;
    end
    check_value("clk cycles with o_locked low", count, LOCK_CYCLES);
    check_value("o_locked", o_locked, 1'b1);
    for (int i = 0; i < 16; i++) begin
      r = next_rand();
      run_command((i < 4) ? i : int'(r[31:30]));  // every mode at least once
    end
    for (int j = 0; j < 6; j++) begin
      r = next_rand();
      run_block(j == 1 || r[31:29] == 3'd0);
    end
    repeat (4) @(negedge clk);
    if (dut0.cmd0.cmd_props.fail_cnt + dut0.data0.data_props.fail_cnt == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      fail_run("concurrent assertions failed during the run");
    end
  end

endmodule
